/* verilog/blinky_params.svh */
`ifndef BLINKY_PARAMS_SVH
`define BLINKY_PARAMS_SVH

// bus widths of the control port
`define BLINKY_ADDR_W 8
`define BLINKY_DATA_W 32

// register map
`define BLINKY_REG_FLAGS 8'h00
`define BLINKY_REG_SHIFT 8'h01
`define BLINKY_REG_FREQ  8'h02
`define BLINKY_REG_COUNT 8'h03

// reset value of the clock shift register
`define BLINKY_DEFAULT_SHIFT 1

// clock frequency in cycles per second, used unless overridden
`define BLINKY_CLK_FREQ_DEFAULT 100_000_000

`endif

/* verilog/blinky_pkg.sv */
`include "blinky_params.svh"

package blinky_pkg;

  // AXI response codes, EXOKAY is never returned by this slave
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_t;

  typedef logic [`BLINKY_ADDR_W-1:0] blinky_addr_t;
  typedef logic [`BLINKY_DATA_W-1:0] blinky_data_t;

  // W channel beat as carried through the skid buffer
  typedef struct packed {
    logic [`BLINKY_DATA_W/8-1:0] strb;
    blinky_data_t                data;
  } blinky_wr_t;

  // layout matches data bits 1:0 of register 0x00
  typedef struct packed {
    logic blink;
    logic enable;
  } blinky_flags_t;

endpackage

/* verilog/axil_skidbuf.sv */
`timescale 1ns/100ps

module axil_skidbuf #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,

  // upstream side
  input  logic i_valid,
  input  T     i_data,
  output logic o_ready,

  // downstream side
  output logic o_valid,
  output T     o_data,
  input  logic i_ready
);

  logic spill_valid;
  logic spill_valid_next;
  T     spill_data;

  // a beat is taken from upstream but the consumer is not ready
  logic spill_load;

  // --------------------------------------------------------------------------
  // output mux
  // --------------------------------------------------------------------------

  // the spilled beat is older, so it always goes out first
  assign o_valid = spill_valid || (i_valid && o_ready);
  assign o_data  = spill_valid ? spill_data : i_data;

  assign spill_load = !spill_valid && i_valid && o_ready && !i_ready;

  always_comb begin
    spill_valid_next = spill_valid;
    if (spill_valid && i_ready) begin
      spill_valid_next = 1'b0;
    end else if (spill_load) begin
      spill_valid_next = 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // state
  // --------------------------------------------------------------------------

  // o_ready is a flop, so it lags the spill state by one edge only
  // right after reset, where it comes up low
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      spill_valid <= 1'b0;
      o_ready     <= 1'b0;
    end else begin
      spill_valid <= spill_valid_next;
      o_ready     <= !spill_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (spill_load) begin
      spill_data <= i_data;
    end
  end

endmodule

/* verilog/blink_gen.sv */
`timescale 1ns/100ps

`include "blinky_params.svh"

module blink_gen #(
  parameter int unsigned CLK_FREQ = `BLINKY_CLK_FREQ_DEFAULT
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  blinky_pkg::blinky_flags_t i_flags,
  input  blinky_pkg::blinky_data_t  i_clk_shift,
  output blinky_pkg::blinky_data_t  o_count,
  output logic                      o_led
);

  import blinky_pkg::*;

  blinky_data_t cnt;
  blinky_data_t cnt_max;
  logic         blinking;

  // --------------------------------------------------------------------------
  // terminal count
  // --------------------------------------------------------------------------

  // shift of zero would mean a full second per phase, treat it as fastest
  assign cnt_max = (i_clk_shift == '0) ? blinky_data_t'(1) :
                   (blinky_data_t'(CLK_FREQ) >> i_clk_shift);

  assign blinking = i_flags.enable && i_flags.blink;

  // --------------------------------------------------------------------------
  // counter and led
  // --------------------------------------------------------------------------

  // one phase lasts cnt_max+1 cycles: cnt runs 0..cnt_max, then wraps
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt   <= '0;
      o_led <= 1'b0;
    end else if (!i_flags.enable) begin
      cnt   <= '0;
      o_led <= 1'b0;
    end else if (!blinking) begin
      // solid mode
      cnt   <= '0;
      o_led <= 1'b1;
    end else if (cnt < cnt_max) begin
      cnt <= cnt + blinky_data_t'(1);
    end else begin
      cnt   <= '0;
      o_led <= ~o_led;
    end
  end

  // host sees the live count, zero when not blinking
  assign o_count = cnt;

endmodule

/* verilog/blinky_regs.sv */
`timescale 1ns/100ps

`include "blinky_params.svh"

module blinky_regs #(
  parameter int unsigned CLK_FREQ = `BLINKY_CLK_FREQ_DEFAULT
) (
  input  logic                        clk,
  input  logic                        rst_n,

  // write address
  input  blinky_pkg::blinky_addr_t    i_awaddr,
  input  logic                        i_awvalid,
  output logic                        o_awready,

  // write data
  input  blinky_pkg::blinky_data_t    i_wdata,
  input  logic [`BLINKY_DATA_W/8-1:0] i_wstrb,
  input  logic                        i_wvalid,
  output logic                        o_wready,

  // write response
  output logic                        o_bvalid,
  output blinky_pkg::axil_resp_t      o_bresp,
  input  logic                        i_bready,

  // read address
  input  blinky_pkg::blinky_addr_t    i_araddr,
  input  logic                        i_arvalid,
  output logic                        o_arready,

  // read data
  output logic                        o_rvalid,
  output blinky_pkg::blinky_data_t    o_rdata,
  output blinky_pkg::axil_resp_t      o_rresp,
  input  logic                        i_rready,

  // to and from the blink generator
  output blinky_pkg::blinky_flags_t   o_flags,
  output blinky_pkg::blinky_data_t    o_clk_shift,
  input  blinky_pkg::blinky_data_t    i_count
);

  import blinky_pkg::*;

  // --------------------------------------------------------------------------
  // write path
  // --------------------------------------------------------------------------

  logic          aw_valid;
  blinky_addr_t  aw_addr;
  logic          w_valid;
  blinky_wr_t    w_in;
  blinky_wr_t    w_beat;
  logic          wr_fire;

  blinky_flags_t flags_next;
  blinky_data_t  shift_next;
  axil_resp_t    bresp_next;

  assign w_in.strb = i_wstrb;
  assign w_in.data = i_wdata;

  axil_skidbuf #(
    .T(blinky_addr_t)
  ) aw_skid_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_awvalid),
    .i_data (i_awaddr),
    .o_ready(o_awready),
    .o_valid(aw_valid),
    .o_data (aw_addr),
    .i_ready(wr_fire)
  );

  axil_skidbuf #(
    .T(blinky_wr_t)
  ) w_skid_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_wvalid),
    .i_data (w_in),
    .o_ready(o_wready),
    .o_valid(w_valid),
    .o_data (w_beat),
    .i_ready(wr_fire)
  );

  // address and data pop together, and only when the B slot can take
  // the response on this same edge
  assign wr_fire = aw_valid && w_valid && (!o_bvalid || i_bready);

  always_comb begin
    flags_next = o_flags;
    shift_next = o_clk_shift;
    bresp_next = OKAY;

    if (wr_fire) begin
      // partial writes are refused outright
      if (w_beat.strb != '1) begin
        bresp_next = SLVERR;
      end else begin
        case (aw_addr)
          `BLINKY_REG_FLAGS: flags_next = blinky_flags_t'(w_beat.data[1:0]);
          `BLINKY_REG_SHIFT: shift_next = w_beat.data;
          `BLINKY_REG_FREQ,
          `BLINKY_REG_COUNT: bresp_next = SLVERR;
          default:           bresp_next = DECERR;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_bvalid    <= 1'b0;
      o_flags     <= '0;
      o_clk_shift <= `BLINKY_DEFAULT_SHIFT;
    end else begin
      o_bvalid    <= wr_fire || (o_bvalid && !i_bready);
      o_flags     <= flags_next;
      o_clk_shift <= shift_next;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      o_bresp <= bresp_next;
    end
  end

  // --------------------------------------------------------------------------
  // read path
  // --------------------------------------------------------------------------

  logic         ar_valid;
  blinky_addr_t ar_addr;
  logic         rd_fire;
  blinky_data_t rdata_next;
  axil_resp_t   rresp_next;

  axil_skidbuf #(
    .T(blinky_addr_t)
  ) ar_skid_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_arvalid),
    .i_data (i_araddr),
    .o_ready(o_arready),
    .o_valid(ar_valid),
    .o_data (ar_addr),
    .i_ready(rd_fire)
  );

  assign rd_fire = ar_valid && (!o_rvalid || i_rready);

  always_comb begin
    rdata_next = '0;
    rresp_next = OKAY;
    case (ar_addr)
      `BLINKY_REG_FLAGS: rdata_next = blinky_data_t'(o_flags);
      `BLINKY_REG_SHIFT: rdata_next = o_clk_shift;
      `BLINKY_REG_FREQ:  rdata_next = blinky_data_t'(CLK_FREQ);
      `BLINKY_REG_COUNT: rdata_next = i_count;
      default:           rresp_next = DECERR;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_rvalid <= 1'b0;
    end else begin
      o_rvalid <= rd_fire || (o_rvalid && !i_rready);
    end
  end

  // read data is captured at accept time, not while the response waits
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      o_rdata <= rdata_next;
      o_rresp <= rresp_next;
    end
  end

endmodule

/* verilog/blinky_top.sv */
`timescale 1ns/100ps

`include "blinky_params.svh"

module blinky_top #(
  parameter int unsigned CLK_FREQ = `BLINKY_CLK_FREQ_DEFAULT
) (
  input  logic                        clk,
  input  logic                        rst_n,

  // AXI-Lite control port
  input  blinky_pkg::blinky_addr_t    i_awaddr,
  input  logic                        i_awvalid,
  output logic                        o_awready,
  input  blinky_pkg::blinky_data_t    i_wdata,
  input  logic [`BLINKY_DATA_W/8-1:0] i_wstrb,
  input  logic                        i_wvalid,
  output logic                        o_wready,
  output logic                        o_bvalid,
  output blinky_pkg::axil_resp_t      o_bresp,
  input  logic                        i_bready,
  input  blinky_pkg::blinky_addr_t    i_araddr,
  input  logic                        i_arvalid,
  output logic                        o_arready,
  output logic                        o_rvalid,
  output blinky_pkg::blinky_data_t    o_rdata,
  output blinky_pkg::axil_resp_t      o_rresp,
  input  logic                        i_rready,

  output logic                        o_led
);

  import blinky_pkg::*;

  blinky_flags_t flags;
  blinky_data_t  clk_shift;
  blinky_data_t  count;

  blinky_regs #(
    .CLK_FREQ(CLK_FREQ)
  ) regs_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_awaddr   (i_awaddr),
    .i_awvalid  (i_awvalid),
    .o_awready  (o_awready),
    .i_wdata    (i_wdata),
    .i_wstrb    (i_wstrb),
    .i_wvalid   (i_wvalid),
    .o_wready   (o_wready),
    .o_bvalid   (o_bvalid),
    .o_bresp    (o_bresp),
    .i_bready   (i_bready),
    .i_araddr   (i_araddr),
    .i_arvalid  (i_arvalid),
    .o_arready  (o_arready),
    .o_rvalid   (o_rvalid),
    .o_rdata    (o_rdata),
    .o_rresp    (o_rresp),
    .i_rready   (i_rready),
    .o_flags    (flags),
    .o_clk_shift(clk_shift),
    .i_count    (count)
  );

  blink_gen #(
    .CLK_FREQ(CLK_FREQ)
  ) gen_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_flags    (flags),
    .i_clk_shift(clk_shift),
    .o_count    (count),
    .o_led      (o_led)
  );

endmodule

/* bench/blinky_tb_axil.svh */
`ifndef BLINKY_TB_AXIL_SVH
`define BLINKY_TB_AXIL_SVH

// ---------------------------------------------------------------------------
// compare tasks
// ---------------------------------------------------------------------------

task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
  if (got !== exp) begin
    $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    abort_run();
  end
endtask

task automatic check_data(input string name, input blinky_data_t got, input blinky_data_t exp);
  if (got !== exp) begin
    $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
    abort_run();
  end
endtask

task automatic check_led(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    abort_run();
  end
endtask

// valid and ready levels of the control port
task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    abort_run();
  end
endtask

// ---------------------------------------------------------------------------
// AXI-Lite driver, entered and left on a falling edge
// ---------------------------------------------------------------------------

// hold the response ready low for 0 to 3 cycles
task automatic stall_ready();
  repeat ($urandom % 4) @(negedge clk);
endtask

// the readies are flops, so their level at the falling edge decides the next rising edge
task automatic send_aw(input blinky_addr_t addr);
  i_awaddr  = addr;
  i_awvalid = 1'b1;
  while (!o_awready) @(negedge clk);
  @(negedge clk);
  i_awvalid = 1'b0;
endtask

task automatic send_w(input blinky_data_t data, input strb_t strb);
  i_wdata  = data;
  i_wstrb  = strb;
  i_wvalid = 1'b1;
  while (!o_wready) @(negedge clk);
  @(negedge clk);
  i_wvalid = 1'b0;
endtask

task automatic send_ar(input blinky_addr_t addr);
  i_araddr  = addr;
  i_arvalid = 1'b1;
  while (!o_arready) @(negedge clk);
  @(negedge clk);
  i_arvalid = 1'b0;
endtask

// order 1 sends AW first, order 2 sends W first, anything else both at once
// a lone beat sits in its spill register, so that channel's ready is low
task automatic write_reg(input blinky_addr_t addr, input blinky_data_t data, input strb_t strb,
                         input int order, output axil_resp_t resp);
  case (order)
    1: begin
      send_aw(addr);
      check_flag("o_awready", o_awready, 1'b0);
      send_w(data, strb);
    end
    2: begin
      send_w(data, strb);
      check_flag("o_wready", o_wready, 1'b0);
      send_aw(addr);
    end
    default: begin
      fork
        send_aw(addr);
        send_w(data, strb);
      join
    end
  endcase
  while (!o_bvalid) @(negedge clk);
  stall_ready();
  check_flag("o_bvalid", o_bvalid, 1'b1);
  resp     = o_bresp;
  i_bready = 1'b1;
  @(negedge clk);
  i_bready = 1'b0;
  if (o_bvalid) begin
    $display("ERROR: write response still valid after its handshake");
    abort_run();
  end
endtask

task automatic read_reg(input blinky_addr_t addr, output axil_resp_t resp,
                        output blinky_data_t data);
  send_ar(addr);
  while (!o_rvalid) @(negedge clk);
  stall_ready();
  check_flag("o_rvalid", o_rvalid, 1'b1);
  resp     = o_rresp;
  data     = o_rdata;
  i_rready = 1'b1;
  @(negedge clk);
  i_rready = 1'b0;
  if (o_rvalid) begin
    $display("ERROR: read response still valid after its handshake");
    abort_run();
  end
endtask

`endif

/* bench/blinky_tb.sv */
`timescale 1ns/100ps

`include "blinky_params.svh"

module blinky_tb;

  import blinky_pkg::*;

  localparam int unsigned CLK_FREQ    = 64;
  localparam int          HALF_PERIOD = 50;
  localparam int          BLINK_SHIFT = 3;
  // one led phase is the terminal count plus the wrap cycle
  localparam int          BLINK_PHASE = (CLK_FREQ >> BLINK_SHIFT) + 1;
  // cycles after a toggle before the counter is read back
  localparam int          COUNT_PROBE = 5;
  // two setup writes, one partial phase, three measured phases,
  // the counter probe and two writes and two reads after it
  localparam int          BLINK_CYCLES = 2 * 20 + 4 * BLINK_PHASE + COUNT_PROBE + 4 * 20;

  typedef logic [`BLINKY_DATA_W/8-1:0] strb_t;

  typedef enum logic [1:0] {
    OP_WR,
    OP_RD,
    OP_LED
  } op_t;

  // for OP_LED, data bit 0 is the expected led level
  typedef struct {
    op_t          op;
    blinky_addr_t addr;
    blinky_data_t data;
    strb_t        strb;
    axil_resp_t   resp;
    blinky_data_t rdata;
  } step_t;

  logic         clk;
  logic         rst_n;
  blinky_addr_t i_awaddr;
  logic         i_awvalid;
  logic         o_awready;
  blinky_data_t i_wdata;
  strb_t        i_wstrb;
  logic         i_wvalid;
  logic         o_wready;
  logic         o_bvalid;
  axil_resp_t   o_bresp;
  logic         i_bready;
  blinky_addr_t i_araddr;
  logic         i_arvalid;
  logic         o_arready;
  logic         o_rvalid;
  blinky_data_t o_rdata;
  axil_resp_t   o_rresp;
  logic         i_rready;
  logic         o_led;

  step_t steps[$];
  bit    table_built;

  blinky_top #(
    .CLK_FREQ(CLK_FREQ)
  ) dut_i (.*);

  always #HALF_PERIOD clk = ~clk;

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  `include "blinky_tb_axil.svh"

  function automatic void add_step(input op_t op, input blinky_addr_t addr,
                                   input blinky_data_t data, input strb_t strb,
                                   input axil_resp_t resp, input blinky_data_t rdata);
    step_t s;
    s.op    = op;
    s.addr  = addr;
    s.data  = data;
    s.strb  = strb;
    s.resp  = resp;
    s.rdata = rdata;
    steps.push_back(s);
  endfunction

  // readies come up low and rise one clock after reset is released
  task automatic check_reset_state();
    check_flag("o_awready", o_awready, 1'b0);
    check_flag("o_wready", o_wready, 1'b0);
    check_flag("o_arready", o_arready, 1'b0);
    check_flag("o_bvalid", o_bvalid, 1'b0);
    check_flag("o_rvalid", o_rvalid, 1'b0);
    @(negedge clk);
    check_flag("o_awready", o_awready, 1'b1);
    check_flag("o_wready", o_wready, 1'b1);
    check_flag("o_arready", o_arready, 1'b1);
  endtask

  // ---------------------------------------------------------------------------
  // stimulus table
  // ---------------------------------------------------------------------------

  function automatic void build_table();
    // reset values
    add_step(OP_RD,  8'h00, 32'h0,         4'h0, OKAY,   32'h0);
    add_step(OP_RD,  8'h01, 32'h0,         4'h0, OKAY,   32'h1);
    add_step(OP_RD,  8'h02, 32'h0,         4'h0, OKAY,   32'h40);
    add_step(OP_LED, 8'h00, 32'h0,         4'h0, OKAY,   32'h0);
    // shift register, full and partial strobe
    add_step(OP_WR,  8'h01, 32'h5,         4'hf, OKAY,   32'h0);
    add_step(OP_RD,  8'h01, 32'h0,         4'h0, OKAY,   32'h5);
    add_step(OP_WR,  8'h01, 32'h9,         4'h3, SLVERR, 32'h0);
    add_step(OP_RD,  8'h01, 32'h0,         4'h0, OKAY,   32'h5);
    // only bits 1:0 land in the flags, enable alone is solid mode
    add_step(OP_WR,  8'h00, 32'hffff_fffd, 4'hf, OKAY,   32'h0);
    add_step(OP_RD,  8'h00, 32'h0,         4'h0, OKAY,   32'h1);
    add_step(OP_LED, 8'h00, 32'h1,         4'h0, OKAY,   32'h0);
    add_step(OP_RD,  8'h03, 32'h0,         4'h0, OKAY,   32'h0);
    add_step(OP_WR,  8'h00, 32'h3,         4'h1, SLVERR, 32'h0);
    add_step(OP_RD,  8'h00, 32'h0,         4'h0, OKAY,   32'h1);
    // read-only and unmapped addresses
    add_step(OP_WR,  8'h02, 32'h0,         4'hf, SLVERR, 32'h0);
    add_step(OP_WR,  8'h03, 32'h0,         4'hf, SLVERR, 32'h0);
    add_step(OP_WR,  8'h04, 32'h1,         4'hf, DECERR, 32'h0);
    add_step(OP_RD,  8'h04, 32'h0,         4'h0, DECERR, 32'h0);
    add_step(OP_RD,  8'hff, 32'h0,         4'h0, DECERR, 32'h0);
    add_step(OP_WR,  8'h00, 32'h0,         4'hf, OKAY,   32'h0);
    add_step(OP_LED, 8'h00, 32'h0,         4'h0, OKAY,   32'h0);
    add_step(OP_RD,  8'h00, 32'h0,         4'h0, OKAY,   32'h0);
    add_step(OP_WR,  8'h80, 32'h0,         4'hf, DECERR, 32'h0);
  endfunction

  // cycles until o_led changes, counted on falling edges
  task automatic measure_toggle(output blinky_data_t cycles);
    logic start;
    start  = o_led;
    cycles = '0;
    do begin
      @(negedge clk);
      cycles = cycles + 1;
    end while (o_led == start);
  endtask

  // ---------------------------------------------------------------------------
  // watchdog and main sequence
  // ---------------------------------------------------------------------------

  initial begin
    int limit;
    wait (table_built);
    limit = 3 + steps.size() * 20 + BLINK_CYCLES;
    repeat (limit) @(posedge clk);
    $display("ERROR: no progress within %0d cycles, the DUT stopped responding", limit);
    abort_run();
  end

  initial begin
    step_t        s;
    axil_resp_t   resp;
    blinky_data_t rdata;
    blinky_data_t interval;
    int           order;
    int           wr_count;

    void'($urandom(32'h5173_0b69));
    clk       = 1'b0;
    rst_n     = 1'b0;
    i_awaddr  = '0;
    i_awvalid = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b0;
    i_araddr  = '0;
    i_arvalid = 1'b0;
    i_rready  = 1'b0;
    wr_count  = 0;
    build_table();
    table_built = 1'b1;

    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_reset_state();

    foreach (steps[i]) begin
      s = steps[i];
      case (s.op)
        OP_WR: begin
          // rotate through both-at-once, AW first and W first
          order    = wr_count % 3;
          wr_count = wr_count + 1;
          write_reg(s.addr, s.data, s.strb, order, resp);
          check_resp("o_bresp", resp, s.resp);
        end
        OP_RD: begin
          read_reg(s.addr, resp, rdata);
          check_resp("o_rresp", resp, s.resp);
          check_data("o_rdata", rdata, s.rdata);
        end
        default: check_led("o_led", o_led, s.data[0]);
      endcase
    end

    // blink mode with shift 3
    write_reg(`BLINKY_REG_SHIFT, BLINK_SHIFT, '1, 0, resp);
    check_resp("o_bresp", resp, OKAY);
    write_reg(`BLINKY_REG_FLAGS, 32'h3, '1, 0, resp);
    check_resp("o_bresp", resp, OKAY);
    // first phase started somewhere inside the write response
    measure_toggle(interval);
    repeat (3) begin
      measure_toggle(interval);
      check_data("o_led toggle interval", interval, BLINK_PHASE);
    end

    // the counter restarts from zero at each toggle
    repeat (COUNT_PROBE) @(negedge clk);
    read_reg(`BLINKY_REG_COUNT, resp, rdata);
    check_resp("o_rresp", resp, OKAY);
    check_data("o_rdata", rdata, COUNT_PROBE);

    // back to solid mode, the counter clears
    write_reg(`BLINKY_REG_FLAGS, 32'h1, '1, 0, resp);
    check_resp("o_bresp", resp, OKAY);
    read_reg(`BLINKY_REG_COUNT, resp, rdata);
    check_resp("o_rresp", resp, OKAY);
    check_data("o_rdata", rdata, 32'h0);
    check_led("o_led", o_led, 1'b1);
    write_reg(`BLINKY_REG_FLAGS, 32'h0, '1, 0, resp);
    check_resp("o_bresp", resp, OKAY);
    check_led("o_led", o_led, 1'b0);

    $display("All checks passed");
    $finish;
  end

endmodule

/* project.f */
+incdir+verilog
+incdir+bench
verilog/blinky_pkg.sv
verilog/axil_skidbuf.sv
verilog/blink_gen.sv
verilog/blinky_regs.sv
verilog/blinky_top.sv
bench/blinky_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the blinky testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module blinky_tb -f project.f -Mdir obj_dir -o blinky_sim \
  && ./obj_dir/blinky_sim > sim.log 2>&1
grep -q "All checks passed" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
